// ==== project.f ====
src/rsPkg.sv
src/issueIf.sv
src/reservationStation.sv
src/fuController.sv
src/latencyTimer.sv
src/aluDatapath.sv
src/tomasuloCore.sv
verification/tomasuloCoreTb.sv

// ==== Makefile ====
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
TOP        = tomasuloCoreTb
FILELIST   = project.f
BUILD_DIR  = obj_dir
PASS_MSG   = Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/tomasuloCoreTb.sv ====
`default_nettype none

module tomasuloCoreTb;

    localparam int clockPeriod       = 40;
    localparam int dispatchTotal     = 300;
    localparam int cyclesPerDispatch = 40;  // generous bound for the watchdog

    logic         clk = 1'b0;
    logic         rst;
    logic         dispatchValid;
    rsPkg::aluOpT aluOp;
    rsPkg::tagT   src1Tag;
    rsPkg::wordT  src1Val;
    rsPkg::tagT   src2Tag;
    rsPkg::wordT  src2Val;
    rsPkg::wordT  imm;
    logic         dispatchReady;
    rsPkg::tagT   dispatchTag;
    logic         cdbValid;
    rsPkg::tagT   cdbTag;
    rsPkg::wordT  cdbValue;

    // reference model, indexed by tag, bit 0 never set
    logic [7:0]  modelBusy;
    rsPkg::wordT expectedValue [8];

    logic [31:0] lfsrState;
    int          accepted;

    // a dispatch that was refused stays on the port, with sources patched from the bus
    logic        holding;
    rsPkg::tagT  heldTag1;
    rsPkg::wordT heldVal1;
    rsPkg::tagT  heldTag2;
    rsPkg::wordT heldVal2;

    tomasuloCore dut (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .aluOp         (aluOp),
        .src1Tag       (src1Tag),
        .src1Val       (src1Val),
        .src2Tag       (src2Tag),
        .src2Val       (src2Val),
        .imm           (imm),
        .dispatchReady (dispatchReady),
        .dispatchTag   (dispatchTag),
        .cdbValid      (cdbValid),
        .cdbTag        (cdbTag),
        .cdbValue      (cdbValue)
    );

    always #(clockPeriod / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);  // one step per bit
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    // either value present or a tag still in flight
    function automatic rsPkg::tagT pickSource();
        rsPkg::tagT pick;
        pick = rsPkg::tagT'(randomBits(3));
        if (!modelBusy[pick]) begin
            pick = '0;
        end
        return pick;
    endfunction

    function automatic rsPkg::tagT lowestFreeTag();
        rsPkg::tagT lowest;
        lowest = '0;
        for (int t = rsPkg::entryCount; t >= 1; t--) begin
            if (!modelBusy[rsPkg::tagT'(t)]) begin
                lowest = rsPkg::tagT'(t);
            end
        end
        return lowest;
    endfunction

    function automatic rsPkg::wordT modelResult(input rsPkg::aluOpT op, input rsPkg::wordT a,
                                                input rsPkg::wordT b, input rsPkg::wordT k);
        case (op)
            rsPkg::opAdd:  return a + b;
            rsPkg::opSub:  return a - b;
            rsPkg::opAnd:  return a & b;
            rsPkg::opOr:   return a | b;
            rsPkg::opXor:  return a ^ b;
            rsPkg::opSll:  return a << b[4:0];
            rsPkg::opAddi: return a + k;
            default:       return a * b;  // opMul, low word
        endcase
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            failRun($sformatf("FAILED at time %0t: %s is %b, expected %b",
                              $time, name, actual, expected));
        end
    endtask

    task automatic compareTag(input string name, input rsPkg::tagT actual,
                              input rsPkg::tagT expected);
        if (actual !== expected) begin
            failRun($sformatf("FAILED at time %0t: %s is %0d, expected %0d",
                              $time, name, actual, expected));
        end
    endtask

    task automatic compareWord(input string name, input rsPkg::wordT actual,
                               input rsPkg::wordT expected);
        if (actual !== expected) begin
            failRun($sformatf("FAILED at time %0t: %s is %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    // called mid-cycle, predicts what the next rising edge does
    task automatic observeCycle();
        rsPkg::tagT  freeTag;
        rsPkg::wordT a;
        rsPkg::wordT b;
        logic        fire;
        freeTag = lowestFreeTag();
        compareTag("dispatchTag", dispatchTag, freeTag);
        compareFlag("dispatchReady", dispatchReady, freeTag != '0);
        fire = dispatchValid && (freeTag != '0);

        if (cdbValid) begin
            if (!modelBusy[cdbTag]) begin
                failRun($sformatf("CDB broadcast at time %0t names tag %0d, which has no %s",
                                  $time, cdbTag, "instruction in flight"));
            end else begin
                compareWord("cdbValue", cdbValue, expectedValue[cdbTag]);
            end
        end

        if (fire) begin
            a = (src1Tag == '0) ? src1Val : expectedValue[src1Tag];
            b = (src2Tag == '0) ? src2Val : expectedValue[src2Tag];
            expectedValue[freeTag] = modelResult(aluOp, a, b, imm);
            modelBusy[freeTag]     = 1'b1;
            accepted++;
        end

        holding  = dispatchValid && !fire;
        heldTag1 = src1Tag;
        heldVal1 = src1Val;
        heldTag2 = src2Tag;
        heldVal2 = src2Val;
        if (cdbValid) begin
            modelBusy[cdbTag] = 1'b0;  // broadcast frees the entry
            if (heldTag1 == cdbTag) begin
                heldTag1 = '0;
                heldVal1 = expectedValue[cdbTag];
            end
            if (heldTag2 == cdbTag) begin
                heldTag2 = '0;
                heldVal2 = expectedValue[cdbTag];
            end
        end
    endtask

    task automatic driveNext();
        if (accepted >= dispatchTotal) begin
            dispatchValid <= 1'b0;
        end else if (holding) begin
            src1Tag <= heldTag1;
            src1Val <= heldVal1;
            src2Tag <= heldTag2;
            src2Val <= heldVal2;
        end else begin
            dispatchValid <= (randomBits(2) != 0);  // valid three times in four
            aluOp         <= rsPkg::aluOpT'(4'(randomBits(3)));
            src1Tag       <= pickSource();
            src1Val       <= randomBits(32);
            src2Tag       <= pickSource();
            src2Val       <= randomBits(32);
            imm           <= randomBits(32);
        end
    endtask

    initial begin
        rst           <= 1'b1;
        dispatchValid <= 1'b0;
        aluOp         <= rsPkg::opAdd;
        src1Tag       <= '0;
        src1Val       <= '0;
        src2Tag       <= '0;
        src2Val       <= '0;
        imm           <= '0;
        lfsrState  = 32'h6599;
        modelBusy  = '0;
        accepted   = 0;
        holding    = 1'b0;
        for (int i = 0; i < 8; i++) begin
            expectedValue[i] = '0;
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compareFlag("dispatchReady", dispatchReady, 1'b1);
        compareTag("dispatchTag", dispatchTag, 3'd1);
        compareFlag("cdbValid", cdbValid, 1'b0);

        // run until every dispatched tag has come back on the bus
        while (accepted < dispatchTotal || modelBusy != '0) begin
            @(posedge clk);
            driveNext();
            @(negedge clk);
            observeCycle();
        end

        $display("Done: no errors");
        $finish;
    end

    initial begin
        #(dispatchTotal * cyclesPerDispatch * clockPeriod);
        failRun($sformatf("timeout: only %0d of %0d dispatches done, tags in flight %b",
                          accepted, dispatchTotal, modelBusy));
    end

endmodule

`default_nettype wire

// ==== src/tomasuloCore.sv ====
`default_nettype none

module tomasuloCore (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   dispatchValid,
    input  rsPkg::aluOpT aluOp,
    input  rsPkg::tagT  src1Tag,
    input  rsPkg::wordT src1Val,
    input  rsPkg::tagT  src2Tag,
    input  rsPkg::wordT src2Val,
    input  rsPkg::wordT imm,
    output logic        dispatchReady,
    output rsPkg::tagT  dispatchTag,
    output logic        cdbValid,
    output rsPkg::tagT  cdbTag,
    output rsPkg::wordT cdbValue
);

    logic timerLoad;
    logic timerDone;
    logic capture;

    issueIf issueBus ();

    // bus outputs loop back into the station for snooping
    reservationStation station (
        .clk           (clk),
        .rst           (rst),
        .dispatchValid (dispatchValid),
        .aluOp         (aluOp),
        .src1Tag       (src1Tag),
        .src1Val       (src1Val),
        .src2Tag       (src2Tag),
        .src2Val       (src2Val),
        .imm           (imm),
        .dispatchReady (dispatchReady),
        .dispatchTag   (dispatchTag),
        .cdbValid      (cdbValid),
        .cdbTag        (cdbTag),
        .cdbValue      (cdbValue),
        .issue         (issueBus.station)
    );

    fuController controller (
        .clk       (clk),
        .rst       (rst),
        .timerDone (timerDone),
        .timerLoad (timerLoad),
        .capture   (capture),
        .cdbValid  (cdbValid),
        .issue     (issueBus.unit)
    );

    // latency picked from the operation on the issue path at accept time
    latencyTimer timer (
        .clk   (clk),
        .rst   (rst),
        .load  (timerLoad),
        .aluOp (issueBus.aluOp),
        .done  (timerDone)
    );

    aluDatapath datapath (
        .clk      (clk),
        .rst      (rst),
        .capture  (capture),
        .issue    (issueBus.datapath),
        .cdbTag   (cdbTag),
        .cdbValue (cdbValue)
    );

endmodule

`default_nettype wire

// ==== src/aluDatapath.sv ====
`default_nettype none

module aluDatapath (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic capture,
    issueIf.datapath  issue,
    output rsPkg::tagT  cdbTag,
    output rsPkg::wordT cdbValue
);

    rsPkg::tagT   tagReg;
    rsPkg::aluOpT opReg;
    rsPkg::wordT  aReg;
    rsPkg::wordT  bReg;
    rsPkg::wordT  immReg;
    rsPkg::wordT  result;

    // owner tag of the instruction in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tagReg <= '0;
        end else if (capture) begin
            tagReg <= issue.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            opReg  <= issue.aluOp;
            aReg   <= issue.opA;
            bReg   <= issue.opB;
            immReg <= issue.imm;
        end
    end

    // registered inputs keep the result steady until the broadcast
    always_comb begin
        case (opReg)
            rsPkg::opAdd:  result = aReg + bReg;
            rsPkg::opSub:  result = aReg - bReg;
            rsPkg::opAnd:  result = aReg & bReg;
            rsPkg::opOr:   result = aReg | bReg;
            rsPkg::opXor:  result = aReg ^ bReg;
            rsPkg::opSll:  result = aReg << bReg[4:0];
            rsPkg::opAddi: result = aReg + immReg;
            rsPkg::opMul:  result = aReg * bReg;  // low 32 bits kept
            default:       result = '0;
        endcase
    end

    assign cdbTag   = tagReg;
    assign cdbValue = result;

endmodule

`default_nettype wire

// ==== src/latencyTimer.sv ====
`default_nettype none

module latencyTimer (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   load,
    input  rsPkg::aluOpT aluOp,
    output logic        done
);

    rsPkg::latencyT count;       // execute cycles still to run
    rsPkg::latencyT loadValue;

    // multiply is the only long operation
    assign loadValue = (aluOp == rsPkg::opMul) ? rsPkg::latencyT'(rsPkg::mulLatency)
                                               : rsPkg::latencyT'(rsPkg::baseLatency);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= loadValue;
        end else if (count != '0) begin
            count <= count - 3'd1;
        end
    end

    // count of one marks the final execute cycle
    assign done = (count == 3'd1);

endmodule

`default_nettype wire

// ==== src/fuController.sv ====
`default_nettype none

module fuController (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic timerDone,
    output logic      timerLoad,   // start the execute countdown
    output logic      capture,     // latch the issued instruction
    output logic      cdbValid,
    issueIf.unit      issue
);

    rsPkg::fuStateT state;
    rsPkg::fuStateT nextState;
    logic           accept;

    assign issue.ready = (state == rsPkg::fuIdle);
    assign accept      = issue.valid && issue.ready;

    assign capture   = accept;
    assign timerLoad = accept;
    assign cdbValid  = (state == rsPkg::fuBcast);

    always_comb begin
        nextState = state;
        case (state)
            rsPkg::fuIdle: begin
                if (accept) begin
                    nextState = rsPkg::fuExec;
                end
            end
            rsPkg::fuExec: begin
                if (timerDone) begin
                    nextState = rsPkg::fuBcast;  // last execute cycle
                end
            end
            rsPkg::fuBcast: begin
                nextState = rsPkg::fuIdle;  // single broadcast cycle
            end
            default: begin
                nextState = rsPkg::fuIdle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= rsPkg::fuIdle;
        end else begin
            state <= nextState;
        end
    end

endmodule

`default_nettype wire

// ==== src/reservationStation.sv ====
`default_nettype none

module reservationStation (
    input  wire logic         clk,
    input  wire logic         rst,
    // dispatch side
    input  wire logic         dispatchValid,
    input  rsPkg::aluOpT      aluOp,
    input  rsPkg::tagT        src1Tag,
    input  rsPkg::wordT       src1Val,
    input  rsPkg::tagT        src2Tag,
    input  rsPkg::wordT       src2Val,
    input  rsPkg::wordT       imm,
    output logic              dispatchReady,
    output rsPkg::tagT        dispatchTag,
    // common data bus snoop
    input  wire logic         cdbValid,
    input  rsPkg::tagT        cdbTag,
    input  rsPkg::wordT       cdbValue,
    issueIf.station           issue
);

    // per-entry control
    logic [rsPkg::entryCount-1:0] busy;
    logic [rsPkg::entryCount-1:0] issued;   // already handed to the unit

    // per-entry payload
    rsPkg::aluOpT entryOp   [rsPkg::entryCount];
    rsPkg::tagT   entryTag1 [rsPkg::entryCount];
    rsPkg::tagT   entryTag2 [rsPkg::entryCount];
    rsPkg::wordT  entryVal1 [rsPkg::entryCount];
    rsPkg::wordT  entryVal2 [rsPkg::entryCount];
    rsPkg::wordT  entryImm  [rsPkg::entryCount];

    logic       freeFound;
    logic [2:0] freeIdx;
    logic       selFound;
    logic [2:0] selIdx;
    logic [2:0] cdbIdx;
    logic       dispatchFire;
    logic       issueFire;

    // lowest free entry, scanned from the top so the lowest index wins
    always_comb begin
        freeFound = 1'b0;
        freeIdx   = '0;
        for (int i = rsPkg::entryCount - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                freeFound = 1'b1;
                freeIdx   = 3'(i);
            end
        end
    end

    // lowest entry with both operands present that has not gone out yet
    always_comb begin
        selFound = 1'b0;
        selIdx   = '0;
        for (int i = rsPkg::entryCount - 1; i >= 0; i--) begin
            if (busy[i] && !issued[i] && entryTag1[i] == '0 && entryTag2[i] == '0) begin
                selFound = 1'b1;
                selIdx   = 3'(i);
            end
        end
    end

    assign dispatchReady = freeFound;
    assign dispatchTag   = freeFound ? freeIdx + 3'd1 : '0;
    assign dispatchFire  = dispatchValid && dispatchReady;

    assign cdbIdx = cdbTag - 3'd1;  // broadcasting entry

    assign issue.valid = selFound;
    assign issue.tag   = selIdx + 3'd1;
    assign issue.aluOp = entryOp[selIdx];
    assign issue.opA   = entryVal1[selIdx];
    assign issue.opB   = entryVal2[selIdx];
    assign issue.imm   = entryImm[selIdx];

    assign issueFire = issue.valid && issue.ready;

    // busy and issued bookkeeping
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= '0;
            issued <= '0;
        end else begin
            if (cdbValid) begin
                busy[cdbIdx]   <= 1'b0;  // broadcast retires the entry
                issued[cdbIdx] <= 1'b0;
            end
            if (dispatchFire) begin
                busy[freeIdx]   <= 1'b1;
                issued[freeIdx] <= 1'b0;
            end
            if (issueFire) begin
                issued[selIdx] <= 1'b1;
            end
        end
    end

    // operand capture and new entry write
    always_ff @(posedge clk) begin
        for (int i = 0; i < rsPkg::entryCount; i++) begin
            if (cdbValid && entryTag1[i] == cdbTag) begin
                entryVal1[i] <= cdbValue;
                entryTag1[i] <= '0;
            end
            if (cdbValid && entryTag2[i] == cdbTag) begin
                entryVal2[i] <= cdbValue;
                entryTag2[i] <= '0;
            end
        end

        // the free entry is never the one being snooped, so this write stands alone
        if (dispatchFire) begin
            entryOp[freeIdx]  <= aluOp;
            entryImm[freeIdx] <= imm;

            if (src1Tag != '0 && cdbValid && src1Tag == cdbTag) begin
                entryTag1[freeIdx] <= '0;        // bypass from the bus
                entryVal1[freeIdx] <= cdbValue;
            end else begin
                entryTag1[freeIdx] <= src1Tag;
                entryVal1[freeIdx] <= src1Val;
            end

            if (src2Tag != '0 && cdbValid && src2Tag == cdbTag) begin
                entryTag2[freeIdx] <= '0;
                entryVal2[freeIdx] <= cdbValue;
            end else begin
                entryTag2[freeIdx] <= src2Tag;
                entryVal2[freeIdx] <= src2Val;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/issueIf.sv ====
`default_nettype none

// one ready instruction travelling from the station to the functional unit
interface issueIf ();

    logic         valid;
    logic         ready;
    rsPkg::tagT   tag;    // entry that will own the result
    rsPkg::aluOpT aluOp;
    rsPkg::wordT  opA;
    rsPkg::wordT  opB;
    rsPkg::wordT  imm;

    modport station (
        output valid, tag, aluOp, opA, opB, imm,
        input  ready
    );

    // controller only handshakes
    modport unit (
        input  valid,
        output ready
    );

    modport datapath (
        input tag, aluOp, opA, opB, imm
    );

endinterface

`default_nettype wire

// ==== src/rsPkg.sv ====
`default_nettype none

package rsPkg;

    // station geometry, tag 0 is reserved for "value present"
    localparam int entryCount = 7;

    // execute cycles per operation class
    localparam int mulLatency  = 4;
    localparam int baseLatency = 1;

    typedef logic [31:0] wordT;     // operand, immediate and result
    typedef logic [2:0]  tagT;      // producer tag = entry index + 1
    typedef logic [2:0]  latencyT;  // must hold mulLatency

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSll,   // shift by low 5 bits of opB
        opAddi,  // opA + imm
        opMul    // low word of the product
    } aluOpT;

    // functional unit sequencing
    typedef enum logic [1:0] {
        fuIdle,
        fuExec,
        fuBcast
    } fuStateT;

endpackage

`default_nettype wire
